//--- periph_pkg.sv
/*
 * Peripheral subsystem definitions
 * Address map, register offsets, interrupt source numbering
 */
`default_nettype none

package periph_pkg;

  // 16 KB window, four 4 KB slots
  localparam logic [31:0] PERIPH_BASE = 32'h2000_0000;

  localparam logic [1:0] IDX_GPIO  = 2'd0;
  localparam logic [1:0] IDX_TIMER = 2'd1;
  localparam logic [1:0] IDX_IRQ   = 2'd2;

  // Byte offsets within a slot
  localparam logic [11:0] GPIO_OUT_OFF = 12'h000;
  localparam logic [11:0] GPIO_DIR_OFF = 12'h004;
  localparam logic [11:0] GPIO_IN_OFF  = 12'h008;
  localparam logic [11:0] GPIO_IEN_OFF = 12'h00C;
  localparam logic [11:0] GPIO_IST_OFF = 12'h010;

  localparam logic [11:0] TMR_CTRL_OFF  = 12'h000;
  localparam logic [11:0] TMR_MTIME_OFF = 12'h004;
  localparam logic [11:0] TMR_CMP0_OFF  = 12'h008;
  localparam logic [11:0] TMR_CMP1_OFF  = 12'h00C;

  localparam logic [11:0] IRQ_PEND_OFF  = 12'h000;
  localparam logic [11:0] IRQ_EN_OFF    = 12'h004;
  localparam logic [11:0] IRQ_CLAIM_OFF = 12'h008;

  localparam int NUM_GPIO    = 8;
  localparam int NUM_EXT_IRQ = 5;
  localparam int NUM_SRC     = 16;

  // Source 0 is reserved and reads as zero
  localparam int SRC_GPIO_BASE  = 1;
  localparam int SRC_TIMER_BASE = 9;
  localparam int SRC_EXT_BASE   = 11;
  localparam int SRC_ID_W       = 4;

  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [17:0] base;
      logic [1:0]  idx;
      logic [9:0]  off;
      logic [1:0]  byte_sel;
    } f;
  } periph_addr_u;

endpackage

`default_nettype wire

//--- obi_slave_port.sv
/*
 * OBI slave port
 * Always grants, one access stage followed by one response stage
 */
`timescale 1ns/1ps
`default_nettype none

module obi_slave_port (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  input  logic [31:0] acc_rdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        acc_valid_o,
  output logic [31:0] acc_addr_o,
  output logic        acc_we_o,
  output logic [3:0]  acc_be_o,
  output logic [31:0] acc_wdata_o
);

  // No back-pressure on the register side
  assign gnt_o = req_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_valid_o <= 1'b0;
      rvalid_o    <= 1'b0;
    end else begin
      acc_valid_o <= req_i;
      rvalid_o    <= acc_valid_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      acc_addr_o  <= addr_i;
      acc_we_o    <= we_i;
      acc_be_o    <= be_i;
      acc_wdata_o <= wdata_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (acc_valid_o) begin
      rdata_o <= acc_we_o ? 32'd0 : acc_rdata_i;
    end
  end

  rvalid_follows_access: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rvalid_o |-> $past(acc_valid_o)
  ) else $error("rvalid without a preceding access");

endmodule

`default_nettype wire

//--- reg_demux.sv
/*
 * Register address decoder
 * Steers the access stage to one block and returns its read word
 */
`timescale 1ns/1ps
`default_nettype none

module reg_demux
  import periph_pkg::*;
(
  input  logic        acc_valid_i,
  input  logic [31:0] acc_addr_i,
  input  logic        acc_we_i,
  input  logic [3:0]  acc_be_i,
  input  logic [31:0] acc_wdata_i,
  input  logic [31:0] gpio_rdata_i,
  input  logic [31:0] tmr_rdata_i,
  input  logic [31:0] irq_rdata_i,
  output logic [31:0] acc_rdata_o,
  output logic [9:0]  reg_off_o,
  output logic [3:0]  reg_be_o,
  output logic [31:0] reg_wdata_o,
  output logic        gpio_wr_o,
  output logic        gpio_rd_o,
  output logic        tmr_wr_o,
  output logic        tmr_rd_o,
  output logic        irq_wr_o,
  output logic        irq_rd_o
);

  periph_addr_u addr;
  logic         in_window;
  logic         hit_gpio;
  logic         hit_tmr;
  logic         hit_irq;

  assign addr      = acc_addr_i;
  assign in_window = acc_valid_i && (addr.raw[31:14] == PERIPH_BASE[31:14]);

  // Slot 3 is unmapped
  assign hit_gpio = in_window && (addr.f.idx == IDX_GPIO);
  assign hit_tmr  = in_window && (addr.f.idx == IDX_TIMER);
  assign hit_irq  = in_window && (addr.f.idx == IDX_IRQ);

  assign gpio_wr_o = hit_gpio && acc_we_i;
  assign gpio_rd_o = hit_gpio && !acc_we_i;
  assign tmr_wr_o  = hit_tmr && acc_we_i;
  assign tmr_rd_o  = hit_tmr && !acc_we_i;
  assign irq_wr_o  = hit_irq && acc_we_i;
  assign irq_rd_o  = hit_irq && !acc_we_i;

  assign reg_off_o   = addr.f.off;
  assign reg_be_o    = acc_be_i;
  assign reg_wdata_o = acc_wdata_i;

  always_comb begin
    acc_rdata_o = 32'd0;
    if (gpio_rd_o) acc_rdata_o = gpio_rdata_i;
    if (tmr_rd_o)  acc_rdata_o = tmr_rdata_i;
    if (irq_rd_o)  acc_rdata_o = irq_rdata_i;
  end

  always_comb begin
    strobe_onehot: assert ($onehot0({gpio_wr_o, gpio_rd_o, tmr_wr_o,
                                     tmr_rd_o, irq_wr_o, irq_rd_o}))
      else $error("more than one register strobe active");
  end

endmodule

`default_nettype wire

//--- gpio_block.sv
/*
 * GPIO block
 * Output, direction, synchronized input and rising-edge interrupt status
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_block
  import periph_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wr_i,
  input  logic                rd_i,
  input  logic [9:0]          off_i,
  input  logic [3:0]          be_i,
  input  logic [31:0]         wdata_i,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [31:0]         rdata_o,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic [NUM_GPIO-1:0] irq_o
);

  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] dir_q;
  logic [NUM_GPIO-1:0] ien_q;
  logic [NUM_GPIO-1:0] ist_q;
  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;
  logic [NUM_GPIO-1:0] prev_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] ist_clr;
  logic                lane0_wr;

  assign lane0_wr = wr_i && be_i[0];
  assign rise     = sync2_q & ~prev_q & ien_q;
  assign ist_clr  = (lane0_wr && off_i == GPIO_IST_OFF[11:2]) ?
                    wdata_i[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q   <= '0;
      dir_q   <= '0;
      ien_q   <= '0;
      ist_q   <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // A new edge wins over a clear in the same cycle
      ist_q   <= (ist_q & ~ist_clr) | rise;
      if (lane0_wr && off_i == GPIO_OUT_OFF[11:2]) out_q <= wdata_i[NUM_GPIO-1:0];
      if (lane0_wr && off_i == GPIO_DIR_OFF[11:2]) dir_q <= wdata_i[NUM_GPIO-1:0];
      if (lane0_wr && off_i == GPIO_IEN_OFF[11:2]) ien_q <= wdata_i[NUM_GPIO-1:0];
    end
  end

  always_comb begin
    rdata_o = 32'd0;
    case (off_i)
      GPIO_OUT_OFF[11:2]: rdata_o = {{(32-NUM_GPIO){1'b0}}, out_q};
      GPIO_DIR_OFF[11:2]: rdata_o = {{(32-NUM_GPIO){1'b0}}, dir_q};
      GPIO_IN_OFF[11:2]:  rdata_o = {{(32-NUM_GPIO){1'b0}}, sync2_q};
      GPIO_IEN_OFF[11:2]: rdata_o = {{(32-NUM_GPIO){1'b0}}, ien_q};
      GPIO_IST_OFF[11:2]: rdata_o = {{(32-NUM_GPIO){1'b0}}, ist_q};
      default:            rdata_o = 32'd0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;
  assign irq_o     = ist_q & ien_q;

  no_read_write_overlap: assert property (
    @(posedge clk_i) disable iff (rst_i) !(wr_i && rd_i)
  ) else $error("GPIO read and write strobes together");

endmodule

`default_nettype wire

//--- mtimer.sv
/*
 * Machine timer
 * Prescaled 32-bit counter compared against two channels
 */
`timescale 1ns/1ps
`default_nettype none

module mtimer
  import periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        wr_i,
  input  logic [9:0]  off_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic [1:0]  irq_o
);

  logic             en_q;
  logic [7:0]       presc_q;
  logic [7:0]       presc_cnt_q;
  logic [31:0]      mtime_q;
  logic [1:0][31:0] cmp_q;

  function automatic logic [31:0] be_merge(input logic [31:0] old_v,
                                           input logic [31:0] new_v,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q        <= 1'b0;
      presc_q     <= '0;
      presc_cnt_q <= '0;
      mtime_q     <= '0;
      cmp_q       <= '0;
    end else begin
      // Tick once every presc_q + 1 cycles
      if (en_q) begin
        if (presc_cnt_q == presc_q) begin
          presc_cnt_q <= '0;
          mtime_q     <= mtime_q + 32'd1;
        end else begin
          presc_cnt_q <= presc_cnt_q + 8'd1;
        end
      end else begin
        presc_cnt_q <= '0;
      end
      // Bus write overrides the increment
      if (wr_i) begin
        case (off_i)
          TMR_CTRL_OFF[11:2]: begin
            if (be_i[0]) en_q <= wdata_i[0];
            if (be_i[1]) presc_q <= wdata_i[15:8];
          end
          TMR_MTIME_OFF[11:2]: mtime_q <= be_merge(mtime_q, wdata_i, be_i);
          TMR_CMP0_OFF[11:2]:  cmp_q[0] <= be_merge(cmp_q[0], wdata_i, be_i);
          TMR_CMP1_OFF[11:2]:  cmp_q[1] <= be_merge(cmp_q[1], wdata_i, be_i);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (off_i)
      TMR_CTRL_OFF[11:2]:  rdata_o = {16'd0, presc_q, 7'd0, en_q};
      TMR_MTIME_OFF[11:2]: rdata_o = mtime_q;
      TMR_CMP0_OFF[11:2]:  rdata_o = cmp_q[0];
      TMR_CMP1_OFF[11:2]:  rdata_o = cmp_q[1];
      default:             rdata_o = 32'd0;
    endcase
  end

  assign irq_o[0] = (mtime_q >= cmp_q[0]);
  assign irq_o[1] = (mtime_q >= cmp_q[1]);

endmodule

`default_nettype wire

//--- irq_ctrl.sv
/*
 * Interrupt controller
 * Latches sources into pending, claim returns lowest enabled ID
 */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
  import periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wr_i,
  input  logic                   rd_i,
  input  logic [9:0]             off_i,
  input  logic [3:0]             be_i,
  input  logic [31:0]            wdata_i,
  input  logic [NUM_GPIO-1:0]    gpio_irq_i,
  input  logic [1:0]             tmr_irq_i,
  input  logic [NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic [31:0]            rdata_o,
  output logic                   irq_o
);

  logic [NUM_SRC-1:0]  src;
  logic [NUM_SRC-1:0]  pend_q;
  logic [NUM_SRC-1:0]  en_q;
  logic [NUM_SRC-1:0]  active;
  logic [NUM_SRC-1:0]  clr_mask;
  logic [SRC_ID_W-1:0] claim_id;
  logic                claim_rd;

  always_comb begin
    src                               = '0;
    src[SRC_GPIO_BASE +: NUM_GPIO]    = gpio_irq_i;
    src[SRC_TIMER_BASE +: 2]          = tmr_irq_i;
    src[SRC_EXT_BASE +: NUM_EXT_IRQ]  = ext_irq_i;
  end

  assign active = pend_q & en_q;
  assign irq_o  = |active;

  // Lowest ID wins, ID 0 means nothing to claim
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) claim_id = SRC_ID_W'(i);
    end
  end

  assign claim_rd = rd_i && (off_i == IRQ_CLAIM_OFF[11:2]);

  always_comb begin
    clr_mask = '0;
    if (claim_rd) clr_mask[claim_id] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= '0;
      en_q   <= '0;
    end else begin
      pend_q <= (pend_q | src) & ~clr_mask;
      if (wr_i && off_i == IRQ_EN_OFF[11:2]) begin
        if (be_i[0]) en_q[7:0] <= wdata_i[7:0];
        if (be_i[1]) en_q[15:8] <= wdata_i[15:8];
      end
    end
  end

  always_comb begin
    case (off_i)
      IRQ_PEND_OFF[11:2]:  rdata_o = {{(32-NUM_SRC){1'b0}}, pend_q};
      IRQ_EN_OFF[11:2]:    rdata_o = {{(32-NUM_SRC){1'b0}}, en_q};
      IRQ_CLAIM_OFF[11:2]: rdata_o = {{(32-SRC_ID_W){1'b0}}, claim_id};
      default:             rdata_o = 32'd0;
    endcase
  end

  claim_needs_irq: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (claim_rd && claim_id != '0) |-> irq_o
  ) else $error("nonzero claim while irq line is low");

endmodule

`default_nettype wire

//--- periph_subsystem.sv
/*
 * Peripheral subsystem top
 * OBI port, decoder, GPIO, timer and interrupt controller
 */
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem
  import periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic [31:0]            addr_i,
  input  logic                   we_i,
  input  logic [3:0]             be_i,
  input  logic [31:0]            wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [31:0]            rdata_o,
  input  logic [NUM_GPIO-1:0]    gpio_i,
  output logic [NUM_GPIO-1:0]    gpio_o,
  output logic [NUM_GPIO-1:0]    gpio_oe_o,
  input  logic [NUM_EXT_IRQ-1:0] irq_ext_i,
  output logic [1:0]             tmr_irq_o,
  output logic                   irq_o
);

  logic                acc_valid;
  logic [31:0]         acc_addr;
  logic                acc_we;
  logic [3:0]          acc_be;
  logic [31:0]         acc_wdata;
  logic [31:0]         acc_rdata;
  logic [9:0]          reg_off;
  logic [3:0]          reg_be;
  logic [31:0]         reg_wdata;
  logic                gpio_wr;
  logic                gpio_rd;
  logic                tmr_wr;
  logic                irq_wr;
  logic                irq_rd;
  logic [31:0]         gpio_rdata;
  logic [31:0]         tmr_rdata;
  logic [31:0]         irq_rdata;
  logic [NUM_GPIO-1:0] gpio_irq;
  logic [1:0]          tmr_irq;

  obi_slave_port u_port (
    .clk_i, .rst_i, .req_i, .addr_i, .we_i, .be_i, .wdata_i,
    .acc_rdata_i(acc_rdata), .gnt_o, .rvalid_o, .rdata_o,
    .acc_valid_o(acc_valid), .acc_addr_o(acc_addr), .acc_we_o(acc_we),
    .acc_be_o(acc_be), .acc_wdata_o(acc_wdata)
  );

  reg_demux u_demux (
    .acc_valid_i(acc_valid), .acc_addr_i(acc_addr), .acc_we_i(acc_we),
    .acc_be_i(acc_be), .acc_wdata_i(acc_wdata), .gpio_rdata_i(gpio_rdata),
    .tmr_rdata_i(tmr_rdata), .irq_rdata_i(irq_rdata), .acc_rdata_o(acc_rdata),
    .reg_off_o(reg_off), .reg_be_o(reg_be), .reg_wdata_o(reg_wdata),
    .gpio_wr_o(gpio_wr), .gpio_rd_o(gpio_rd), .tmr_wr_o(tmr_wr),
    .tmr_rd_o(), .irq_wr_o(irq_wr), .irq_rd_o(irq_rd)
  );

  gpio_block u_gpio (
    .clk_i, .rst_i, .wr_i(gpio_wr), .rd_i(gpio_rd), .off_i(reg_off),
    .be_i(reg_be), .wdata_i(reg_wdata), .gpio_i, .rdata_o(gpio_rdata),
    .gpio_o, .gpio_oe_o, .irq_o(gpio_irq)
  );

  // Timer has no read side effects, so no read strobe
  mtimer u_timer (
    .clk_i, .rst_i, .wr_i(tmr_wr), .off_i(reg_off), .be_i(reg_be),
    .wdata_i(reg_wdata), .rdata_o(tmr_rdata), .irq_o(tmr_irq)
  );

  irq_ctrl u_irq (
    .clk_i, .rst_i, .wr_i(irq_wr), .rd_i(irq_rd), .off_i(reg_off),
    .be_i(reg_be), .wdata_i(reg_wdata), .gpio_irq_i(gpio_irq),
    .tmr_irq_i(tmr_irq), .ext_irq_i(irq_ext_i), .rdata_o(irq_rdata), .irq_o
  );

  assign tmr_irq_o = tmr_irq;

endmodule

`default_nettype wire

//--- tb_model.svh
/*
 * Register and interrupt reference model for the peripheral subsystem testbench
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0]  m_out;
logic [7:0]  m_dir;
logic [7:0]  m_ien;
logic [7:0]  m_ist;
logic [7:0]  m_pins;
logic        m_tmr_en;
logic [7:0]  m_presc;
logic [31:0] m_mtime;
logic [31:0] m_cmp0;
logic [31:0] m_cmp1;
// Pending is only tracked once the claim drain has emptied it
logic [15:0] m_pend;
logic [15:0] m_en;
logic [4:0]  m_ext;

task automatic clear_model();
  m_out    = '0;
  m_dir    = '0;
  m_ien    = '0;
  m_ist    = '0;
  m_pins   = '0;
  m_tmr_en = 1'b0;
  m_presc  = '0;
  m_mtime  = '0;
  m_cmp0   = '0;
  m_cmp1   = '0;
  m_pend   = '0;
  m_en     = '0;
  m_ext    = '0;
endtask

function automatic logic [31:0] lane_merge(input logic [31:0] old_v,
                                           input logic [31:0] new_v,
                                           input logic [3:0]  be);
  logic [31:0] mask;
  mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  return (old_v & ~mask) | (new_v & mask);
endfunction

function automatic logic [3:0] lowest_claim();
  logic [15:0] act;
  act = m_pend & m_en;
  for (int i = 1; i < 16; i++) begin
    if (act[i]) return 4'(i);
  end
  return 4'd0;
endfunction

function automatic logic irq_expected();
  return |(m_pend & m_en);
endfunction

// Applies one bus access to the model and returns the expected response word
function automatic logic [31:0] predict_access(input logic        we,
                                               input logic [31:0] addr,
                                               input logic [3:0]  be,
                                               input logic [31:0] wd);
  logic [11:0] off;
  logic [31:0] rd;
  logic [31:0] tmp;
  logic [3:0]  id;
  off = {addr[11:2], 2'b00};
  rd  = 32'd0;
  // Outside the window or in slot 3 nothing responds
  if (addr[31:14] != PERIPH_BASE[31:14] || addr[13:12] == 2'd3) return rd;
  if (addr[13:12] == IDX_GPIO) begin
    if (we && be[0]) begin
      if (off == GPIO_OUT_OFF) m_out = wd[7:0];
      if (off == GPIO_DIR_OFF) m_dir = wd[7:0];
      if (off == GPIO_IEN_OFF) m_ien = wd[7:0];
      if (off == GPIO_IST_OFF) m_ist = m_ist & ~wd[7:0];
    end else if (!we) begin
      case (off)
        GPIO_OUT_OFF: rd = {24'd0, m_out};
        GPIO_DIR_OFF: rd = {24'd0, m_dir};
        GPIO_IN_OFF:  rd = {24'd0, m_pins};
        GPIO_IEN_OFF: rd = {24'd0, m_ien};
        GPIO_IST_OFF: rd = {24'd0, m_ist};
        default:      rd = 32'd0;
      endcase
    end
  end else if (addr[13:12] == IDX_TIMER) begin
    if (we) begin
      case (off)
        TMR_CTRL_OFF: begin
          if (be[0]) m_tmr_en = wd[0];
          if (be[1]) m_presc = wd[15:8];
        end
        TMR_MTIME_OFF: m_mtime = lane_merge(m_mtime, wd, be);
        TMR_CMP0_OFF:  m_cmp0 = lane_merge(m_cmp0, wd, be);
        TMR_CMP1_OFF:  m_cmp1 = lane_merge(m_cmp1, wd, be);
        default: ;
      endcase
    end else begin
      case (off)
        TMR_CTRL_OFF:  rd = {16'd0, m_presc, 7'd0, m_tmr_en};
        TMR_MTIME_OFF: rd = m_mtime;
        TMR_CMP0_OFF:  rd = m_cmp0;
        TMR_CMP1_OFF:  rd = m_cmp1;
        default:       rd = 32'd0;
      endcase
    end
  end else begin
    if (we && off == IRQ_EN_OFF) begin
      tmp  = lane_merge({16'd0, m_en}, wd, be);
      m_en = tmp[15:0];
    end else if (!we) begin
      case (off)
        IRQ_PEND_OFF: rd = {16'd0, m_pend};
        IRQ_EN_OFF:   rd = {16'd0, m_en};
        IRQ_CLAIM_OFF: begin
          id         = lowest_claim();
          rd         = {28'd0, id};
          m_pend[id] = 1'b0;
          // Sources still high latch again on the next edge
          m_pend     = m_pend | {m_ext, 11'd0};
        end
        default: rd = 32'd0;
      endcase
    end
  end
  return rd;
endfunction

`endif

//--- tb_periph_subsystem.sv
/*
 * Peripheral subsystem testbench
 * Random OBI traffic checked against a register and interrupt model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsystem
  import periph_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int RST_CYCLES      = 10;
  localparam int N_STORE         = 300;
  localparam int N_GPIO_ROUNDS   = 40;
  localparam int N_CMP_ROUNDS    = 40;
  localparam int N_TICK_READS    = 20;
  localparam int N_IRQ_ROUNDS    = 40;
  // Generous transaction count, each one worth three cycles
  localparam int TXN_BUDGET      = N_STORE + 8 * N_GPIO_ROUNDS + 8 * N_CMP_ROUNDS +
                                   6 * N_TICK_READS + 30 * N_IRQ_ROUNDS + 60;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + 3 * TXN_BUDGET + 500;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        req_i;
  logic [31:0] addr_i;
  logic        we_i;
  logic [3:0]  be_i;
  logic [31:0] wdata_i;
  logic        gnt_o;
  logic        rvalid_o;
  logic [31:0] rdata_o;
  logic [7:0]  gpio_i;
  logic [7:0]  gpio_o;
  logic [7:0]  gpio_oe_o;
  logic [4:0]  irq_ext_i;
  logic [1:0]  tmr_irq_o;
  logic        irq_o;

  // Response bookkeeping, indexed by transaction number
  logic [31:0] exp_data [64];
  bit          exp_chk [64];
  int          grant_cyc [64];
  int          n_issued = 0;
  int          n_granted = 0;
  int          n_done = 0;
  int          cyc = 0;
  logic [31:0] last_rdata;
  int          last_grant;

  `include "tb_model.svh"

  periph_subsystem dut0 (
    .clk_i, .rst_i, .req_i, .addr_i, .we_i, .be_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o, .gpio_i, .gpio_o, .gpio_oe_o,
    .irq_ext_i, .tmr_irq_o, .irq_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] reg_addr(input logic [1:0] idx, input logic [11:0] off);
    return PERIPH_BASE | {18'd0, idx, off};
  endfunction

  // Grants are counted at the rising edge, where req_i is stable
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (!rst_i) begin
      check_value("gnt_o", 32'(req_i), 32'(gnt_o));
      if (gnt_o) begin
        grant_cyc[n_granted % 64] = cyc;
        n_granted = n_granted + 1;
      end
    end
  end

  // Response cycle runs from the edge after the accepting edge
  always @(negedge clk_i) begin
    if (!rst_i && rvalid_o) begin
      if (n_done >= n_granted || n_done >= n_issued) begin
        $display("Error at %0t ns: rvalid_o without an outstanding request", $time);
        abort_run();
      end else begin
        check_value("rvalid_o delay", 32'd1, 32'(cyc - grant_cyc[n_done % 64]));
        if (exp_chk[n_done % 64]) check_value("rdata_o", exp_data[n_done % 64], rdata_o);
        last_rdata = rdata_o;
        last_grant = grant_cyc[n_done % 64];
        n_done     = n_done + 1;
      end
    end
  end

  task automatic issue(input logic we, input logic [31:0] addr, input logic [3:0] be,
                       input logic [31:0] wd, input bit chk);
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wd;
    exp_data[n_issued % 64] = predict_access(we, addr, be, wd);
    exp_chk[n_issued % 64]  = chk;
    n_issued = n_issued + 1;
  endtask

  task automatic go_idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      req_i = 1'b0;
    end
  endtask

  task automatic drain();
    go_idle(1);
    wait (n_done == n_issued);
    // One more cycle lets a claimed source latch again
    @(negedge clk_i);
  endtask

  task automatic random_store_access();
    logic [31:0] addr;
    logic [31:0] wd;
    int          kind;
    kind = $urandom_range(0, 11);
    wd   = $urandom;
    case (kind)
      0:  addr = reg_addr(IDX_GPIO, GPIO_OUT_OFF);
      1:  addr = reg_addr(IDX_GPIO, GPIO_DIR_OFF);
      2:  addr = reg_addr(IDX_GPIO, GPIO_IN_OFF);
      3:  addr = reg_addr(IDX_GPIO, GPIO_IEN_OFF);
      4:  addr = reg_addr(IDX_GPIO, GPIO_IST_OFF);
      5:  addr = reg_addr(IDX_TIMER, TMR_CTRL_OFF);
      6:  addr = reg_addr(IDX_TIMER, TMR_MTIME_OFF);
      7:  addr = reg_addr(IDX_TIMER, TMR_CMP0_OFF);
      8:  addr = reg_addr(IDX_TIMER, TMR_CMP1_OFF);
      9:  addr = reg_addr(IDX_IRQ, IRQ_EN_OFF);
      10: addr = reg_addr(2'd3, 12'($urandom_range(0, 1023) * 4));
      default: begin
        addr = $urandom;
        if (addr[31:14] == PERIPH_BASE[31:14]) addr[31] = ~addr[31];
      end
    endcase
    // Timer stays stopped here
    if (kind == 5) wd[0] = 1'b0;
    issue(1'($urandom), addr, 4'($urandom), wd, 1'b1);
  endtask

  task automatic drop_and_drain();
    @(negedge clk_i);
    irq_ext_i = '0;
    m_ext     = '0;
    go_idle(2);
    while (lowest_claim() != 4'd0) begin
      issue(1'b0, reg_addr(IDX_IRQ, IRQ_CLAIM_OFF), 4'hF, 32'd0, 1'b1);
      drain();
    end
    issue(1'b0, reg_addr(IDX_IRQ, IRQ_CLAIM_OFF), 4'hF, 32'd0, 1'b1);
    drain();
    check_value("irq_o", 32'd0, 32'(irq_o));
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin : main_seq
    logic [7:0]  pins;
    logic [4:0]  ext;
    logic [31:0] mt;
    logic [31:0] c0;
    logic [31:0] c1;
    logic [31:0] prev_val;
    int          prev_grant;
    void'($urandom(79821));
    rst_i     = 1'b1;
    req_i     = 1'b0;
    addr_i    = '0;
    we_i      = 1'b0;
    be_i      = '0;
    wdata_i   = '0;
    gpio_i    = '0;
    irq_ext_i = '0;
    clear_model();
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;

    // Back-to-back storage traffic with occasional pauses
    for (int i = 0; i < N_STORE; i++) begin
      random_store_access();
      if ($urandom_range(0, 9) == 0) begin
        drain();
        check_value("gpio_o", 32'(m_out), 32'(gpio_o));
        check_value("gpio_oe_o", 32'(m_dir), 32'(gpio_oe_o));
      end
    end
    drain();
    check_value("gpio_o", 32'(m_out), 32'(gpio_o));
    check_value("gpio_oe_o", 32'(m_dir), 32'(gpio_oe_o));

    // GPIO edges, pins held well past the synchronizer
    for (int i = 0; i < N_GPIO_ROUNDS; i++) begin
      if (i % 4 == 0) begin
        issue(1'b1, reg_addr(IDX_GPIO, GPIO_IEN_OFF), 4'h1, 32'($urandom_range(0, 255)), 1'b1);
        drain();
      end
      pins = 8'($urandom);
      @(negedge clk_i);
      gpio_i = pins;
      m_ist  = m_ist | (pins & ~m_pins & m_ien);
      m_pins = pins;
      go_idle(5);
      issue(1'b0, reg_addr(IDX_GPIO, GPIO_IN_OFF), 4'hF, 32'd0, 1'b1);
      issue(1'b0, reg_addr(IDX_GPIO, GPIO_IST_OFF), 4'hF, 32'd0, 1'b1);
      issue(1'b1, reg_addr(IDX_GPIO, GPIO_IST_OFF), 4'h1, $urandom, 1'b1);
      issue(1'b0, reg_addr(IDX_GPIO, GPIO_IST_OFF), 4'hF, 32'd0, 1'b1);
      drain();
    end

    // Compare levels with the timer stopped
    for (int i = 0; i < N_CMP_ROUNDS; i++) begin
      mt = $urandom;
      c0 = ($urandom_range(0, 1) == 1) ? mt + 32'($urandom_range(0, 8)) - 32'd4 : $urandom;
      c1 = ($urandom_range(0, 1) == 1) ? mt + 32'($urandom_range(0, 8)) - 32'd4 : $urandom;
      issue(1'b1, reg_addr(IDX_TIMER, TMR_MTIME_OFF), 4'hF, mt, 1'b1);
      issue(1'b1, reg_addr(IDX_TIMER, TMR_CMP0_OFF), 4'hF, c0, 1'b1);
      issue(1'b1, reg_addr(IDX_TIMER, TMR_CMP1_OFF), 4'hF, c1, 1'b1);
      drain();
      check_value("tmr_irq_o[0]", 32'(m_mtime >= m_cmp0), 32'(tmr_irq_o[0]));
      check_value("tmr_irq_o[1]", 32'(m_mtime >= m_cmp1), 32'(tmr_irq_o[1]));
    end

    // Running timer with prescale 0
    issue(1'b1, reg_addr(IDX_TIMER, TMR_MTIME_OFF), 4'hF, 32'($urandom_range(0, 1000)), 1'b1);
    issue(1'b1, reg_addr(IDX_TIMER, TMR_CTRL_OFF), 4'h3, 32'h1, 1'b1);
    drain();
    prev_val   = '0;
    prev_grant = 0;
    for (int i = 0; i <= N_TICK_READS; i++) begin
      issue(1'b0, reg_addr(IDX_TIMER, TMR_MTIME_OFF), 4'hF, 32'd0, 1'b0);
      drain();
      if (i > 0) begin
        check_value("mtime increment", 32'd1, 32'(last_rdata > prev_val));
        check_value("mtime bound", 32'd1,
                    32'((last_rdata - prev_val) <= 32'(last_grant - prev_grant)));
      end
      prev_val   = last_rdata;
      prev_grant = last_grant;
      go_idle($urandom_range(0, 3));
    end
    issue(1'b1, reg_addr(IDX_TIMER, TMR_CTRL_OFF), 4'h3, 32'h0, 1'b1);
    issue(1'b0, reg_addr(IDX_TIMER, TMR_MTIME_OFF), 4'hF, 32'd0, 1'b0);
    drain();
    m_mtime = last_rdata;
    issue(1'b0, reg_addr(IDX_TIMER, TMR_MTIME_OFF), 4'hF, 32'd0, 1'b1);
    drain();

    // Silence GPIO and timer sources, then empty pending
    issue(1'b1, reg_addr(IDX_GPIO, GPIO_IEN_OFF), 4'h1, 32'd0, 1'b1);
    issue(1'b1, reg_addr(IDX_TIMER, TMR_MTIME_OFF), 4'hF, 32'd0, 1'b1);
    issue(1'b1, reg_addr(IDX_TIMER, TMR_CMP0_OFF), 4'hF, 32'hFFFF_FFFF, 1'b1);
    issue(1'b1, reg_addr(IDX_TIMER, TMR_CMP1_OFF), 4'hF, 32'hFFFF_FFFF, 1'b1);
    issue(1'b1, reg_addr(IDX_IRQ, IRQ_EN_OFF), 4'h3, 32'h0000_FFFF, 1'b1);
    drain();
    for (int i = 0; i < NUM_SRC; i++) begin
      issue(1'b0, reg_addr(IDX_IRQ, IRQ_CLAIM_OFF), 4'hF, 32'd0, 1'b0);
      drain();
    end
    m_pend = '0;
    issue(1'b0, reg_addr(IDX_IRQ, IRQ_PEND_OFF), 4'hF, 32'd0, 1'b1);
    drain();
    check_value("irq_o", 32'd0, 32'(irq_o));

    // External sources, random enables and claims
    for (int i = 0; i < N_IRQ_ROUNDS; i++) begin
      ext = 5'($urandom);
      @(negedge clk_i);
      irq_ext_i = ext;
      m_ext     = ext;
      m_pend    = m_pend | {ext, 11'd0};
      go_idle(2);
      issue(1'b1, reg_addr(IDX_IRQ, IRQ_EN_OFF), 4'($urandom), $urandom, 1'b1);
      issue(1'b0, reg_addr(IDX_IRQ, IRQ_PEND_OFF), 4'hF, 32'd0, 1'b1);
      drain();
      check_value("irq_o", 32'(irq_expected()), 32'(irq_o));
      issue(1'b0, reg_addr(IDX_IRQ, IRQ_CLAIM_OFF), 4'hF, 32'd0, 1'b1);
      drain();
      check_value("irq_o", 32'(irq_expected()), 32'(irq_o));
      if (i % 4 == 3) drop_and_drain();
    end
    drop_and_drain();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
periph_pkg.sv
obi_slave_port.sv
reg_demux.sv
gpio_block.sv
mtimer.sv
irq_ctrl.sv
periph_subsystem.sv
tb_periph_subsystem.sv

//--- Makefile
# Verilator simulation of the peripheral subsystem
LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_periph_subsystem -Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_periph_subsystem | tee $(LOG)
	grep -q "^STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
